// ==== verilog/lbpPkg.sv ====
`default_nettype none

package lbpPkg;

  localparam int WeightBits = 16;

  // unsigned fixed point, 8 fraction bits, 256 is one
  typedef logic [WeightBits-1:0] weight_t;

  typedef struct packed {
    logic [7:0]           center;
    logic [2:0]           radius;
    // [angle][pixel], pixel 0 is A and pixel 3 is D
    logic [3:0][3:0][7:0] corners;
  } patch_t;

  typedef struct packed {
    logic [2:0] radius;
    logic [1:0] angle;
    logic [7:0] center;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] d;
  } sampleReq_t;

  typedef struct packed {
    logic [7:0] value;
    logic       exact;
    logic [1:0] angle;
    logic [7:0] center;
  } sample_t;

  // bit index equals angle
  typedef struct packed {
    logic [3:0] code;
    logic [3:0] exactMask;
  } lbpCode_t;

endpackage

`default_nettype wire

// ==== verilog/patchSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module patchSequencer
  import lbpPkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       patchStrobe,
  input  patch_t     patch,
  input  logic       full,
  output logic       busy,
  output logic       push,
  output sampleReq_t pushData
);

  patch_t     patchReg;
  logic [1:0] angle;

  // stall on a full queue, the request stays put
  assign push = busy && !full;

  always_comb begin
    pushData.radius = patchReg.radius;
    pushData.angle  = angle;
    pushData.center = patchReg.center;
    pushData.a      = patchReg.corners[angle][0];
    pushData.b      = patchReg.corners[angle][1];
    pushData.c      = patchReg.corners[angle][2];
    pushData.d      = patchReg.corners[angle][3];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      angle <= 2'd0;
    end else if (!busy) begin
      if (patchStrobe) begin
        busy  <= 1'b1;
        angle <= 2'd0;
      end
    end else if (push) begin
      angle <= angle + 2'd1;
      // last angle pushed, patch done
      if (angle == 2'd3) begin
        busy <= 1'b0;
      end
    end
  end

  // strobes during busy are dropped
  always_ff @(posedge clk) begin
    if (patchStrobe && !busy) begin
      patchReg <= patch;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sampleQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module sampleQueue
  import lbpPkg::*;
#(
  parameter int Depth = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push,
  input  sampleReq_t pushData,
  input  logic       pop,
  output sampleReq_t popData,
  output logic       full,
  output logic       empty
);

  localparam int AddrBits = $clog2(Depth);

  sampleReq_t        mem [Depth];
  logic [AddrBits:0] wrPtr;
  logic [AddrBits:0] rdPtr;

  // extra pointer bit tells full from empty
  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[AddrBits] != rdPtr[AddrBits]) &&
                 (wrPtr[AddrBits-1:0] == rdPtr[AddrBits-1:0]);

  // head entry shown before the pop
  assign popData = mem[rdPtr[AddrBits-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (push && !full) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop && !empty) begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full) begin
      mem[wrPtr[AddrBits-1:0]] <= pushData;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bilinearInterp.sv ====
`timescale 1ns/1ps
`default_nettype none

module bilinearInterp
  import lbpPkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       empty,
  input  sampleReq_t popData,
  output logic       pop,
  output logic       sampleValid,
  output sample_t    sample
);

  // entry is {1 - dx, 1 - dy, dx, dy}, indexed [radius][angle]
  // angles 0..3 are 45, 135, 225 and 315 degrees
  localparam weight_t [3:0] WTable [8][4] = '{
    // code 0 sits on the integer grid
    '{{16'h0100, 16'h0100, 16'h0000, 16'h0000}, {16'h0100, 16'h0100, 16'h0000, 16'h0000},
      {16'h0100, 16'h0100, 16'h0000, 16'h0000}, {16'h0100, 16'h0100, 16'h0000, 16'h0000}},
    '{{16'h006A, 16'h0096, 16'h0096, 16'h006A}, {16'h006A, 16'h006A, 16'h0096, 16'h0096},
      {16'h0096, 16'h006A, 16'h006A, 16'h0096}, {16'h0096, 16'h0096, 16'h006A, 16'h006A}},
    '{{16'h001F, 16'h00E1, 16'h00E1, 16'h001F}, {16'h001F, 16'h001F, 16'h00E1, 16'h00E1},
      {16'h00E1, 16'h001F, 16'h001F, 16'h00E1}, {16'h00E1, 16'h00E1, 16'h001F, 16'h001F}},
    '{{16'h00D4, 16'h002C, 16'h002C, 16'h00D4}, {16'h00D4, 16'h00D4, 16'h002C, 16'h002C},
      {16'h002C, 16'h00D4, 16'h00D4, 16'h002C}, {16'h002C, 16'h002C, 16'h00D4, 16'h00D4}},
    '{{16'h0089, 16'h0077, 16'h0077, 16'h0089}, {16'h0089, 16'h0089, 16'h0077, 16'h0077},
      {16'h0077, 16'h0089, 16'h0089, 16'h0077}, {16'h0077, 16'h0077, 16'h0089, 16'h0089}},
    '{{16'h003E, 16'h00C2, 16'h00C2, 16'h003E}, {16'h003E, 16'h003E, 16'h00C2, 16'h00C2},
      {16'h00C2, 16'h003E, 16'h003E, 16'h00C2}, {16'h00C2, 16'h00C2, 16'h003E, 16'h003E}},
    '{{16'h00F4, 16'h000C, 16'h000C, 16'h00F4}, {16'h00F4, 16'h00F4, 16'h000C, 16'h000C},
      {16'h000C, 16'h00F4, 16'h00F4, 16'h000C}, {16'h000C, 16'h000C, 16'h00F4, 16'h00F4}},
    '{{16'h00A8, 16'h0058, 16'h0058, 16'h00A8}, {16'h00A8, 16'h00A8, 16'h0058, 16'h0058},
      {16'h0058, 16'h00A8, 16'h00A8, 16'h0058}, {16'h0058, 16'h0058, 16'h00A8, 16'h00A8}}
  };

  weight_t [3:0]                   w;
  logic [3:0][2*WeightBits-1:0]    wProd;
  logic [3:0][7:0]                 pix;
  logic [3:0][2*WeightBits-1:0]    pixProd;
  logic [WeightBits-1:0]           result;
  logic [1:3]                      validP;
  logic [1:3][1:0]                 angleP;
  logic [1:3][7:0]                 centerP;

  // never stalls, so drain whenever something is queued
  assign pop = !empty;
  assign w   = WTable[popData.radius][popData.angle];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      validP <= '0;
    end else begin
      validP <= {pop, validP[1:2]};
    end
  end

  always_ff @(posedge clk) begin
    // stage 1: corner weights, A B C D order
    wProd[0] <= w[3] * w[2];
    wProd[1] <= w[1] * w[2];
    wProd[2] <= w[0] * w[3];
    wProd[3] <= w[1] * w[0];
    pix      <= {popData.d, popData.c, popData.b, popData.a};
    // stage 2
    for (int i = 0; i < 4; i++) begin
      pixProd[i] <= wProd[i][WeightBits+7:8] * {pix[i], 8'd0};
    end
    // stage 3, sum wraps in 16 bits
    result <= pixProd[0][WeightBits+7:8] + pixProd[1][WeightBits+7:8] +
              pixProd[2][WeightBits+7:8] + pixProd[3][WeightBits+7:8];
    angleP  <= {popData.angle, angleP[1:2]};
    centerP <= {popData.center, centerP[1:2]};
  end

  assign sampleValid = validP[3];

  always_comb begin
    // round up only above one half
    sample.value  = (result[7:0] > 8'h80) ? result[15:8] + 8'd1 : result[15:8];
    sample.exact  = (result[7:0] == 8'd0);
    sample.angle  = angleP[3];
    sample.center = centerP[3];
  end

endmodule

`default_nettype wire

// ==== verilog/codeAssembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module codeAssembler
  import lbpPkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     sampleValid,
  input  sample_t  sample,
  output logic     codeValid,
  output lbpCode_t code
);

  lbpCode_t acc;
  lbpCode_t accNext;

  always_comb begin
    accNext                           = acc;
    accNext.code[sample.angle]        = (sample.value >= sample.center);
    accNext.exactMask[sample.angle]   = sample.exact;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc       <= '0;
      codeValid <= 1'b0;
    end else begin
      codeValid <= sampleValid && (sample.angle == 2'd3);
      if (sampleValid) begin
        // angle 3 closes the patch
        if (sample.angle == 2'd3) begin
          acc <= '0;
        end else begin
          acc <= accNext;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sampleValid && (sample.angle == 2'd3)) begin
      code <= accNext;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lbpSampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module lbpSampler
  import lbpPkg::*;
#(
  parameter int Depth = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     patchStrobe,
  input  patch_t   patch,
  output logic     busy,
  output logic     sampleValid,
  output sample_t  sample,
  output logic     codeValid,
  output lbpCode_t code
);

  logic       push;
  logic       full;
  logic       pop;
  logic       empty;
  sampleReq_t pushData;
  sampleReq_t popData;

  patchSequencer sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .patchStrobe (patchStrobe),
    .patch       (patch),
    .full        (full),
    .busy        (busy),
    .push        (push),
    .pushData    (pushData)
  );

  sampleQueue #(
    .Depth (Depth)
  ) queue (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (push),
    .pushData (pushData),
    .pop      (pop),
    .popData  (popData),
    .full     (full),
    .empty    (empty)
  );

  bilinearInterp interp (
    .clk         (clk),
    .rst_n       (rst_n),
    .empty       (empty),
    .popData     (popData),
    .pop         (pop),
    .sampleValid (sampleValid),
    .sample      (sample)
  );

  codeAssembler assembler (
    .clk         (clk),
    .rst_n       (rst_n),
    .sampleValid (sampleValid),
    .sample      (sample),
    .codeValid   (codeValid),
    .code        (code)
  );

endmodule

`default_nettype wire

// ==== bench/lbpSampler_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module protocolChecks #(
  parameter int Depth = 4
) (
  input logic clk,
  input logic rst_n,
  input logic busy,
  input logic push,
  input logic pop,
  input logic sampleValid,
  input logic codeValid
);

  int failures = 0;
  int level;

  // queue occupancy tracked apart from the full and empty flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      level <= 0;
    end else begin
      level <= level + int'(push) - int'(pop);
    end
  end

  noPushWhenFull: assert property (@(posedge clk) disable iff (!rst_n) push |-> level < Depth)
    else begin
      failures++;
      $error("push while queue full");
    end

  noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> level > 0)
    else begin
      failures++;
      $error("pop while queue empty");
    end

  // fixed three stage interpolator latency
  popToSample: assert property (@(posedge clk) disable iff (!rst_n) pop |-> ##3 sampleValid)
    else begin
      failures++;
      $error("sampleValid missing three cycles after pop");
    end

  quietAfterReset: assert property (@(posedge clk) !rst_n |=> !busy && !sampleValid && !codeValid)
    else begin
      failures++;
      $error("outputs not low after reset");
    end

endmodule

bind lbpSampler protocolChecks #(
  .Depth (Depth)
) checks (
  .clk         (clk),
  .rst_n       (rst_n),
  .busy        (busy),
  .push        (push),
  .pop         (pop),
  .sampleValid (sampleValid),
  .codeValid   (codeValid)
);

`default_nettype wire

// ==== bench/lbpSamplerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lbpSamplerTb
  import lbpPkg::*;
();

  localparam int Depth     = 4;
  localparam int NumRandom = 200;
  localparam int NumGrid   = 20;
  localparam int Timeout   = 200;

  logic     clk;
  logic     rst_n;
  logic     patchStrobe;
  patch_t   patch;
  logic     busy;
  logic     sampleValid;
  sample_t  sample;
  logic     codeValid;
  lbpCode_t code;

  integer   seed = 32'he5996e5d;
  sample_t  expSamples[$];
  lbpCode_t expCodes[$];
  int       sampleErrors;
  int       codeErrors;
  int       busyErrors;
  int       otherErrors;
  int       sampleCount;
  int       codeCount;
  int       accepted;
  logic     timedOut;

  lbpSampler #(
    .Depth (Depth)
  ) i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .patchStrobe (patchStrobe),
    .patch       (patch),
    .busy        (busy),
    .sampleValid (sampleValid),
    .sample      (sample),
    .codeValid   (codeValid),
    .code        (code)
  );

  always #20 clk = ~clk;

  task automatic checkSample(input sample_t expected, input sample_t actual);
    if (actual !== expected) begin
      sampleErrors++;
      $display("[ERROR] %0t sample: expected %h, actual %h", $time, expected, actual);
    end
  endtask

  task automatic checkCode(input lbpCode_t expected, input lbpCode_t actual);
    if (actual !== expected) begin
      codeErrors++;
      $display("[ERROR] %0t code: expected %h, actual %h", $time, expected, actual);
    end
  endtask

  task automatic checkBusy(input logic expected, input logic actual);
    if (actual !== expected) begin
      busyErrors++;
      $display("[ERROR] %0t busy: expected %b, actual %b", $time, expected, actual);
    end
  endtask

  // sub-pixel offset per radius code, mirrored per angle below
  function automatic weight_t offsetFor(input logic [2:0] radius);
    case (radius)
      3'd1:    return 16'h0096;
      3'd2:    return 16'h00E1;
      3'd3:    return 16'h002C;
      3'd4:    return 16'h0077;
      3'd5:    return 16'h00C2;
      3'd6:    return 16'h000C;
      3'd7:    return 16'h0058;
      default: return 16'h0000;
    endcase
  endfunction

  function automatic sample_t modelSample(input patch_t p, input logic [1:0] angle);
    weight_t                 one;
    weight_t                 q;
    weight_t                 dx;
    weight_t                 dy;
    weight_t                 wx;
    weight_t                 wy;
    logic [2*WeightBits-1:0] prod;
    logic [WeightBits-1:0]   acc;
    sample_t                 s;
    one = 16'h0100;
    q   = offsetFor(p.radius);
    dx  = (angle <= 2'd1) ? q : one - q;
    dy  = (angle == 2'd1 || angle == 2'd2) ? q : one - q;
    // code 0 sits on the grid
    if (p.radius == 3'd0) begin
      dx = '0;
      dy = '0;
    end
    acc = '0;
    for (int k = 0; k < 4; k++) begin
      // B and D lean on dx, C and D on dy
      wx   = k[0] ? dx : one - dx;
      wy   = k[1] ? dy : one - dy;
      prod = wx * wy;
      prod = prod[WeightBits+7:8] * {p.corners[angle][k], 8'd0};
      acc  = acc + prod[WeightBits+7:8];
    end
    s.value  = acc[15:8] + ((acc[7:0] > 8'h80) ? 8'd1 : 8'd0);
    s.exact  = (acc[7:0] == 8'd0);
    s.angle  = angle;
    s.center = p.center;
    return s;
  endfunction

  function automatic patch_t randomPatch(input logic offGrid);
    patch_t p;
    p.corners = {$random(seed), $random(seed), $random(seed), $random(seed)};
    p.center  = $random(seed);
    p.radius  = offGrid ? 3'(1 + $unsigned($random(seed)) % 7) : 3'd0;
    return p;
  endfunction

  task automatic sendPatch(input patch_t p, input logic extraStrobe);
    int       waitCycles;
    sample_t  s;
    lbpCode_t c;
    waitCycles = 0;
    do begin
      @(posedge clk);
      waitCycles++;
    end while (busy && waitCycles < Timeout);
    if (busy) begin
      $display("timeout: busy stayed high for %0d cycles", Timeout);
      otherErrors++;
      timedOut = 1'b1;
    end else begin
      patchStrobe <= 1'b1;
      patch       <= p;
      c = '0;
      for (int a = 0; a < 4; a++) begin
        s = modelSample(p, 2'(a));
        expSamples.push_back(s);
        c.code[a]      = (s.value >= s.center);
        c.exactMask[a] = s.exact;
      end
      expCodes.push_back(c);
      accepted++;
      @(posedge clk);
      patchStrobe <= 1'b0;
      @(posedge clk);
      // busy rose the cycle after the strobe
      checkBusy(1'b1, busy);
      // busy is high here, this strobe must be dropped
      if (extraStrobe) begin
        patchStrobe <= 1'b1;
        patch       <= ~p;
        @(posedge clk);
        patchStrobe <= 1'b0;
      end
    end
  endtask

  task automatic drain();
    int waitCycles;
    waitCycles = 0;
    while ((expSamples.size() != 0 || expCodes.size() != 0) && waitCycles < Timeout) begin
      @(posedge clk);
      waitCycles++;
    end
    if (expSamples.size() != 0 || expCodes.size() != 0) begin
      $display("timeout: %0d samples and %0d codes never arrived",
               expSamples.size(), expCodes.size());
      otherErrors++;
      timedOut = 1'b1;
    end else begin
      // room for any stray output
      repeat (8) @(posedge clk);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (sampleValid) begin
        sampleCount++;
        if (expSamples.size() == 0) begin
          $display("sample arrived at %0t with none expected", $time);
          otherErrors++;
        end else begin
          checkSample(expSamples.pop_front(), sample);
        end
      end
      if (codeValid) begin
        codeCount++;
        if (expCodes.size() == 0) begin
          $display("code arrived at %0t with none expected", $time);
          otherErrors++;
        end else begin
          checkCode(expCodes.pop_front(), code);
        end
      end
    end
  end

  initial begin
    patch_t p;
    int     assertFails;
    clk          = 1'b0;
    rst_n        = 1'b0;
    patchStrobe  = 1'b0;
    patch        = '0;
    sampleErrors = 0;
    codeErrors   = 0;
    busyErrors   = 0;
    otherErrors  = 0;
    sampleCount  = 0;
    codeCount    = 0;
    accepted     = 0;
    timedOut     = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (6) @(posedge clk);
    if (sampleCount != 0 || codeCount != 0) begin
      $display("output strobe seen before any patch was sent");
      otherErrors++;
    end
    for (int n = 0; n < NumRandom + NumGrid && !timedOut; n++) begin
      p = randomPatch(n < NumRandom);
      sendPatch(p, (n % 7) == 3);
    end
    if (!timedOut) begin
      drain();
    end
    if (!timedOut && (sampleCount != 4 * accepted || codeCount != accepted)) begin
      $display("%0d samples and %0d codes for %0d accepted patches",
               sampleCount, codeCount, accepted);
      otherErrors++;
    end
    assertFails = i_dut.checks.failures;
    $display("errors: sample %0d, code %0d, busy %0d, other %0d, assertion %0d",
             sampleErrors, codeErrors, busyErrors, otherErrors, assertFails);
    if (sampleErrors + codeErrors + busyErrors + otherErrors + assertFails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/lbpPkg.sv
verilog/patchSequencer.sv
verilog/sampleQueue.sv
verilog/bilinearInterp.sv
verilog/codeAssembler.sv
verilog/lbpSampler.sv
bench/lbpSampler_sva.sv
bench/lbpSamplerTb.sv

// ==== Bender.yml ====
package:
  name: lbpSampler

sources:
  - verilog/lbpPkg.sv
  - verilog/patchSequencer.sv
  - verilog/sampleQueue.sv
  - verilog/bilinearInterp.sv
  - verilog/codeAssembler.sv
  - verilog/lbpSampler.sv
  - target: test
    files:
      - bench/lbpSampler_sva.sv
      - bench/lbpSamplerTb.sv
